//--- flist.f
+incdir+src
src/cpu_pkg.sv
src/wordMem.sv
src/regFile.sv
src/controlDecode.sv
src/alu.sv
src/pcUnit.sv
src/cpuCore.sv
verification/clockGen.sv
verification/cpuCore_checker.sv
verification/cpuCore_tb.sv

//--- Bender.yml
package:
  name: cpu_core

sources:
  # Synthesizable core
  - include_dirs:
      - src
    files:
      - src/cpu_pkg.sv
      - src/wordMem.sv
      - src/regFile.sv
      - src/controlDecode.sv
      - src/alu.sv
      - src/pcUnit.sv
      - src/cpuCore.sv
  # Simulation only
  - target: test
    include_dirs:
      - src
    files:
      - verification/clockGen.sv
      - verification/cpuCore_checker.sv
      - verification/cpuCore_tb.sv

//--- verification/cpuCore_tb.sv
// Core testbench: program table, loader loop, trace checks, halt window, timeout
`timescale 1ns/10ps
`include "cpu_consts.svh"

module cpuCore_tb;

    import cpu_pkg::*;

    // Program word and the register write it should trace
    typedef struct packed {
        instr_t  word;
        logic    expWrite;
        regIdx_t expIdx;
        word_t   expData;
    } row_t;

    logic      clk;
    logic      rst;
    logic      run;
    imemLoad_t load;
    wbTrace_t  trace;
    logic      halted;

    row_t progTable [$];
    int   seenCount [`CPU_IMEM_DEPTH];
    int   errorCount;
    int   checkCount;
    int   cycleCount;
    int   cycleLimit;

    clockGen i_clockGen (.clk(clk), .rst(rst));

    cpuCore i_cpuCore (
        .clk(clk), .rst(rst), .run(run), .load(load), .trace(trace), .halted(halted)
    );

    // Instruction encoders, one per format
    function automatic instr_t i1Word(input logic [4:0] op, input regIdx_t rs,
                                      input regIdx_t rd, input logic [4:0] imm5);
        return {op, rs, rd, imm5};
    endfunction

    function automatic instr_t i2Word(input logic [4:0] op, input regIdx_t rs,
                                      input logic [7:0] imm8);
        return {op, rs, imm8};
    endfunction

    function automatic instr_t rWord(input regIdx_t rs, input regIdx_t rt,
                                     input regIdx_t rd, input logic [1:0] fn);
        return {`OPC_RTYPE, rs, rt, rd, fn};
    endfunction

    function automatic instr_t jWord(input logic [4:0] op, input logic [10:0] disp);
        return {op, disp};
    endfunction

    task automatic addRow(input instr_t word, input logic expWrite, input regIdx_t idx,
                          input word_t data);
        row_t r;
        r.word = word;
        r.expWrite = expWrite;
        r.expIdx = idx;
        r.expData = data;
        progTable.push_back(r);
    endtask

    // Rows in address order, row n sits at PC 2n
    task automatic buildTable();
        addRow(i2Word(`OPC_LBI, 3'd1, 8'h05), 1'b1, 3'd1, 16'h0005);
        addRow(i2Word(`OPC_LBI, 3'd2, 8'hFD), 1'b1, 3'd2, 16'hFFFD);
        addRow(i1Word(`OPC_ADDI, 3'd1, 3'd3, 5'd7), 1'b1, 3'd3, 16'h000C);
        // 3 - 5
        addRow(i1Word(`OPC_SUBI, 3'd1, 3'd4, 5'd3), 1'b1, 3'd4, 16'hFFFE);
        // Zero-extended immediates
        addRow(i1Word(`OPC_XORI, 3'd2, 3'd5, 5'h1F), 1'b1, 3'd5, 16'hFFE2);
        addRow(i1Word(`OPC_ANDNI, 3'd2, 3'd6, 5'h11), 1'b1, 3'd6, 16'hFFEC);
        addRow(rWord(3'd1, 3'd2, 3'd3, 2'b00), 1'b1, 3'd3, 16'h0002);
        // r2 - r1
        addRow(rWord(3'd1, 3'd2, 3'd4, 2'b01), 1'b1, 3'd4, 16'hFFF8);
        addRow(rWord(3'd2, 3'd6, 3'd5, 2'b10), 1'b1, 3'd5, 16'h0011);
        addRow(rWord(3'd2, 3'd1, 3'd6, 2'b11), 1'b1, 3'd6, 16'hFFF8);
        // Stores to byte 0 and byte 8, then loads back
        addRow(i1Word(`OPC_ST, 3'd1, 3'd6, 5'b11011), 1'b0, 3'd0, 16'h0000);
        addRow(i1Word(`OPC_ST, 3'd1, 3'd3, 5'd3), 1'b0, 3'd0, 16'h0000);
        addRow(i1Word(`OPC_LD, 3'd3, 3'd0, 5'd6), 1'b1, 3'd0, 16'h0002);
        addRow(i1Word(`OPC_LD, 3'd4, 3'd5, 5'd8), 1'b1, 3'd5, 16'hFFF8);
        // r0 is 2, falls through
        addRow(i2Word(`OPC_BEQZ, 3'd0, 8'd4), 1'b0, 3'd0, 16'h0000);
        addRow(i1Word(`OPC_ADDI, 3'd1, 3'd1, 5'd1), 1'b1, 3'd1, 16'h0006);
        addRow(i2Word(`OPC_BNEZ, 3'd1, 8'd2), 1'b0, 3'd0, 16'h0000);
        // Skipped
        addRow(i1Word(`OPC_ADDI, 3'd1, 3'd1, 5'd1), 1'b0, 3'd0, 16'h0000);
        addRow(i1Word(`OPC_SUBI, 3'd1, 3'd2, 5'd6), 1'b1, 3'd2, 16'h0000);
        addRow(i2Word(`OPC_BEQZ, 3'd2, 8'd2), 1'b0, 3'd0, 16'h0000);
        // Skipped
        addRow(i2Word(`OPC_LBI, 3'd1, 8'h7F), 1'b0, 3'd0, 16'h0000);
        // JAL at PC 42 links 44, lands on PC 50
        addRow(jWord(`OPC_JAL, 11'd6), 1'b1, 3'd7, 16'h002C);
        addRow(jWord(`OPC_J, 11'd2), 1'b0, 3'd0, 16'h0000);
        // Skipped
        addRow(i1Word(`OPC_ADDI, 3'd1, 3'd1, 5'd1), 1'b0, 3'd0, 16'h0000);
        addRow(jWord(`OPC_HALT, 11'd0), 1'b0, 3'd0, 16'h0000);
        addRow(i1Word(`OPC_ADDI, 3'd7, 3'd6, 5'd4), 1'b1, 3'd6, 16'h0030);
        // Back to the row after JAL
        addRow(i2Word(`OPC_JR, 3'd7, 8'd0), 1'b0, 3'd0, 16'h0000);
    endtask

    // Trace check at each rising edge
    always @(posedge clk) begin
        int row;
        if (!rst && trace.valid) begin
            row = int'(trace.pc >> 1);
            if (trace.pc[0] || row >= progTable.size()) begin
                errorCount++;
                $display("Trace at %0t carries PC %h outside the program", $time, trace.pc);
            end else if (!progTable[row].expWrite) begin
                errorCount++;
                $display("Trace at %0t from row %0d, which must not write a register",
                         $time, row);
            end else begin
                seenCount[row]++;
                checkCount++;
                if (trace.idx !== progTable[row].expIdx) begin
                    errorCount++;
                    $display("Error at %0t: trace.idx (row %0d) expected %0d, actual %0d",
                             $time, row, progTable[row].expIdx, trace.idx);
                end
                if (trace.data !== progTable[row].expData) begin
                    errorCount++;
                    $display("Error at %0t: trace.data (row %0d) expected %h, actual %h",
                             $time, row, progTable[row].expData, trace.data);
                end
            end
        end
    end

    // Watchdog
    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout: the core did not halt within %0d cycles", cycleLimit);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin
        imemLoad_t entry;
        run = 1'b0;
        load = '0;
        errorCount = 0;
        checkCount = 0;
        cycleCount = 0;
        foreach (seenCount[i]) begin
            seenCount[i] = 0;
        end
        buildTable();
        // Reset, load, execution and halt window with margin
        cycleLimit = 3 + progTable.size() + 3 * progTable.size() + 20;

        @(negedge rst);
        // Loader writes one row per edge while run is low
        foreach (progTable[i]) begin
            @(posedge clk);
            entry.we = 1'b1;
            entry.addr = ($clog2(`CPU_IMEM_DEPTH))'(i);
            entry.data = progTable[i].word;
            load <= entry;
        end
        @(posedge clk);
        load <= '0;
        run <= 1'b1;

        while (!halted) begin
            @(posedge clk);
        end

        // Core must stay frozen
        repeat (10) begin
            @(posedge clk);
            if (trace.valid) begin
                errorCount++;
                $display("Trace valid at %0t although the core is halted", $time);
            end
            if (!halted) begin
                errorCount++;
                $display("Halted dropped at %0t without a reset", $time);
            end
        end

        // Each expected write exactly once
        foreach (progTable[i]) begin
            if (progTable[i].expWrite && seenCount[i] == 0) begin
                errorCount++;
                $display("Row %0d at PC %0d never traced its register write", i, 2 * i);
            end else if (progTable[i].expWrite && seenCount[i] > 1) begin
                errorCount++;
                $display("Row %0d at PC %0d traced %0d times instead of once",
                         i, 2 * i, seenCount[i]);
            end
        end

        $display("Trace checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- verification/cpuCore_checker.sv
// Bound assertions on halted stickiness, frozen trace while stopped, halted clear after reset
`timescale 1ns/10ps

module cpuCore_checker (
    input logic              clk,
    input logic              rst,
    input logic              run,
    input logic              halted,
    input cpu_pkg::wbTrace_t trace
);

    // Once set, halted only falls through reset
    haltHolds: assert property (@(posedge clk) (halted && !rst) |=> halted)
        else $error("halted dropped without reset");

    // Stopped core traces no write and keeps its PC over the edge
    traceQuiet: assert property (@(posedge clk)
        (!rst && (halted || !run)) |-> !trace.valid ##1 $stable(trace.pc))
        else $error("trace valid or PC moved while halted or run low");

    // Reset clears halted on the next edge
    resetClears: assert property (@(posedge clk) rst |=> !halted)
        else $error("halted still set after reset");

endmodule

// Attach to every core instance
bind cpuCore cpuCore_checker i_checker (
    .clk(clk), .rst(rst), .run(run), .halted(halted), .trace(trace)
);

//--- verification/clockGen.sv
// Testbench clock source with 40 ns period and a 3-cycle synchronous reset
`timescale 1ns/10ps

module clockGen (
    output logic clk,
    output logic rst
);

    // 20 ns half period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Reset held over the first three rising edges
    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

//--- src/cpuCore.sv
// Single-cycle core top: memories, register file, decoder, ALU, PC unit, muxes and trace
`timescale 1ns/10ps
`include "cpu_consts.svh"

module cpuCore (
    input  logic               clk,
    input  logic               rst,
    input  logic               run,
    input  cpu_pkg::imemLoad_t load,
    output cpu_pkg::wbTrace_t  trace,
    output logic               halted
);

    import cpu_pkg::*;

    instr_t instr;
    ctrl_t  ctrl;
    word_t  imm;
    word_t  pc;
    word_t  pcPlus2;
    word_t  regA;
    word_t  regB;
    word_t  aluB;
    word_t  aluResult;
    word_t  memRaw;
    word_t  memData;
    word_t  wrData;
    word_t  loadAddr;
    logic   aluZero;
    logic   retire;

    // Instruction retires only while running and not halted
    assign retire = run & ~halted;

    // Loader word address to byte address
    assign loadAddr = word_t'({load.addr, 1'b0});

    wordMem #(.payload_t(instr_t), .DEPTH(`CPU_IMEM_DEPTH)) i_imem (
        .clk(clk), .we(load.we), .waddr(loadAddr), .wdata(load.data),
        .raddr(pc), .rdata(instr)
    );

    controlDecode i_decode (.instr(instr), .ctrl(ctrl), .imm(imm));

    // rs on port A, rt or I1 rd on port B
    regFile i_regs (
        .clk(clk), .rst(rst), .rdAddrA(instr.body[10:8]), .rdAddrB(instr.body[7:5]),
        .rdDataA(regA), .rdDataB(regB), .we(ctrl.regWrite & retire),
        .wrAddr(ctrl.destSel), .wrData(wrData)
    );

    // Operand B mux, zero on branches so the flag tests rs alone
    assign aluB = ctrl.branch ? '0 : (ctrl.aluSrcImm ? imm : regB);

    alu i_alu (
        .inA(regA), .inB(aluB), .op(ctrl.aluOp), .invA(ctrl.invA), .invB(ctrl.invB),
        .cin(ctrl.cin), .result(aluResult), .zero(aluZero)
    );

    // Store data from port B
    wordMem #(.payload_t(word_t), .DEPTH(`CPU_DMEM_DEPTH)) i_dmem (
        .clk(clk), .we(ctrl.memWrite & retire), .waddr(aluResult), .wdata(regB),
        .raddr(aluResult), .rdata(memRaw)
    );
    assign memData = ctrl.memRead ? memRaw : '0;

    pcUnit i_pc (
        .clk(clk), .rst(rst), .run(run), .ctrl(ctrl), .regA(regA), .imm(imm),
        .regZero(aluZero), .pc(pc), .pcPlus2(pcPlus2), .halted(halted)
    );

    // Write-back source
    always_comb begin
        case (ctrl.writeSel)
            WB_MEM: wrData = memData;
            WB_LINK: wrData = pcPlus2;
            default: wrData = aluResult;
        endcase
    end

    // Trace mirrors the register write of the current instruction
    always_comb begin
        trace.valid = ctrl.regWrite & retire;
        trace.idx = ctrl.destSel;
        trace.data = wrData;
        trace.pc = pc;
    end

endmodule

//--- src/pcUnit.sv
// Program counter register, next-PC selection and halted flag
`timescale 1ns/10ps

module pcUnit (
    input  logic           clk,
    input  logic           rst,
    input  logic           run,
    input  cpu_pkg::ctrl_t ctrl,
    input  cpu_pkg::word_t regA,
    input  cpu_pkg::word_t imm,
    input  logic           regZero,
    output cpu_pkg::word_t pc,
    output cpu_pkg::word_t pcPlus2,
    output logic           halted
);

    import cpu_pkg::*;

    word_t relTarget;
    word_t nextPc;
    logic  branchTaken;

    assign pcPlus2 = pc + word_t'(2);

    // J, JAL and branches share the PC+2 relative target
    assign relTarget = pcPlus2 + imm;

    // BEQZ on zero, BNEZ on nonzero
    assign branchTaken = ctrl.branch & (regZero ^ ctrl.branchNonZero);

    always_comb begin
        if (ctrl.jumpReg) begin
            nextPc = regA + imm;
        end else if (ctrl.jump || branchTaken) begin
            nextPc = relTarget;
        end else begin
            nextPc = pcPlus2;
        end
    end

    // PC holds on run low, freezes at the HALT instruction
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
            halted <= 1'b0;
        end else if (run && !halted) begin
            if (ctrl.halt) begin
                halted <= 1'b1;
            end else begin
                pc <= nextPc;
            end
        end
    end

endmodule

//--- src/alu.sv
// 16-bit ALU, add with carry-in, XOR, AND and pass-B, optional operand inversion, zero flag
`timescale 1ns/10ps

module alu (
    input  cpu_pkg::word_t  inA,
    input  cpu_pkg::word_t  inB,
    input  cpu_pkg::aluOp_t op,
    input  logic            invA,
    input  logic            invB,
    input  logic            cin,
    output cpu_pkg::word_t  result,
    output logic            zero
);

    import cpu_pkg::*;

    // Operands after inversion
    word_t opA;
    word_t opB;

    assign opA = invA ? ~inA : inA;
    assign opB = invB ? ~inB : inB;

    always_comb begin
        case (op)
            // Carry out is dropped, no flags kept
            ALU_ADD: result = opA + opB + word_t'(cin);
            ALU_XOR: result = opA ^ opB;
            // AND-NOT comes from invB
            ALU_ANDN: result = opA & opB;
            ALU_PASSB: result = opB;
            default: result = '0;
        endcase
    end

    // Also serves the branch test with B forced to 0
    assign zero = (result == '0);

endmodule

//--- src/controlDecode.sv
// Opcode decoder producing the control word, plus the immediate extender
`timescale 1ns/10ps
`include "cpu_consts.svh"

module controlDecode (
    input  cpu_pkg::instr_t instr,
    output cpu_pkg::ctrl_t  ctrl,
    output cpu_pkg::word_t  imm
);

    import cpu_pkg::*;

    // Extended immediate candidates
    word_t imm5s;
    word_t imm5z;
    word_t imm8s;
    word_t imm11s;

    assign imm5s  = {{(`CPU_WIDTH-5){instr.body[4]}}, instr.body[4:0]};
    assign imm5z  = {{(`CPU_WIDTH-5){1'b0}}, instr.body[4:0]};
    assign imm8s  = {{(`CPU_WIDTH-8){instr.body[7]}}, instr.body[7:0]};
    assign imm11s = {{(`CPU_WIDTH-11){instr.body[10]}}, instr.body[10:0]};

    always_comb begin
        // Defaults: no side effects, I1 destination, 5-bit signed immediate
        ctrl = '0;
        ctrl.writeSel = WB_ALU;
        ctrl.aluOp = ALU_ADD;
        ctrl.destSel = instr.body[7:5];
        imm = imm5s;
        case (instr.opcode)
            `OPC_HALT: ctrl.halt = 1'b1;
            `OPC_NOP: ctrl = '0;
            `OPC_J: begin
                ctrl.jump = 1'b1;
                imm = imm11s;
            end
            // Target is rs plus offset
            `OPC_JR: begin
                ctrl.jumpReg = 1'b1;
                imm = imm8s;
            end
            `OPC_JAL: begin
                ctrl.jump = 1'b1;
                ctrl.link = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.writeSel = WB_LINK;
                ctrl.destSel = regIdx_t'(`CPU_LINK_REG);
                imm = imm11s;
            end
            `OPC_ADDI: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            // imm - rs as ~rs + imm + 1
            `OPC_SUBI: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.invA = 1'b1;
                ctrl.cin = 1'b1;
            end
            `OPC_XORI: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp = ALU_XOR;
                imm = imm5z;
            end
            `OPC_ANDNI: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp = ALU_ANDN;
                ctrl.invB = 1'b1;
                imm = imm5z;
            end
            // Zero test goes through the ALU, core forces B to 0
            `OPC_BEQZ, `OPC_BNEZ: begin
                ctrl.branch = 1'b1;
                ctrl.branchNonZero = instr.opcode[0];
                imm = imm8s;
            end
            `OPC_ST: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            `OPC_LD: begin
                ctrl.memRead = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.writeSel = WB_MEM;
                ctrl.aluSrcImm = 1'b1;
            end
            // rs is both source field and destination
            `OPC_LBI: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp = ALU_PASSB;
                ctrl.destSel = instr.body[10:8];
                imm = imm8s;
            end
            `OPC_RTYPE: begin
                ctrl.regWrite = 1'b1;
                ctrl.destSel = instr.body[4:2];
                case (instr.body[1:0])
                    2'b00: ctrl.aluOp = ALU_ADD;
                    // rt - rs
                    2'b01: begin
                        ctrl.invA = 1'b1;
                        ctrl.cin = 1'b1;
                    end
                    2'b10: ctrl.aluOp = ALU_XOR;
                    default: begin
                        ctrl.aluOp = ALU_ANDN;
                        ctrl.invB = 1'b1;
                    end
                endcase
            end
            // Undefined opcodes fall back to NOP
            default: ctrl = '0;
        endcase
    end

endmodule

//--- src/regFile.sv
// Eight-entry register file, two async read ports and one sync write port
`timescale 1ns/10ps
`include "cpu_consts.svh"

module regFile (
    input  logic             clk,
    input  logic             rst,
    input  cpu_pkg::regIdx_t rdAddrA,
    input  cpu_pkg::regIdx_t rdAddrB,
    output cpu_pkg::word_t   rdDataA,
    output cpu_pkg::word_t   rdDataB,
    input  logic             we,
    input  cpu_pkg::regIdx_t wrAddr,
    input  cpu_pkg::word_t   wrData
);

    import cpu_pkg::*;

    // Register array
    word_t regs [`CPU_NREGS];

    // Reads see the old value until the next cycle
    assign rdDataA = regs[rdAddrA];
    assign rdDataB = regs[rdAddrB];

    // Reset clears every register
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `CPU_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wrAddr] <= wrData;
        end
    end

endmodule

//--- src/wordMem.sv
// Byte-addressed word memory, async read and sync write, payload set by type parameter
`timescale 1ns/10ps

module wordMem #(
    parameter type payload_t = logic [15:0],
    parameter int  DEPTH     = 64
) (
    input  logic           clk,
    input  logic           we,
    input  cpu_pkg::word_t waddr,
    input  payload_t       wdata,
    input  cpu_pkg::word_t raddr,
    output payload_t       rdata
);

    // Word index width, bit 0 of the byte address is dropped
    localparam int addrBits = $clog2(DEPTH);

    // Storage array
    payload_t mem [DEPTH];

    logic [addrBits-1:0] wIdx;
    logic [addrBits-1:0] rIdx;

    // Upper address bits wrap
    assign wIdx = waddr[addrBits:1];
    assign rIdx = raddr[addrBits:1];

    // Combinational read
    assign rdata = mem[rIdx];

    // Write on the edge
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wIdx] <= wdata;
        end
    end

endmodule

//--- src/cpu_pkg.sv
// Shared core types: instruction, control, ALU op, loader and trace structs
`include "cpu_consts.svh"

package cpu_pkg;

    // Data word and register index
    typedef logic [`CPU_WIDTH-1:0] word_t;
    typedef logic [$clog2(`CPU_NREGS)-1:0] regIdx_t;

    // Raw instruction, body is viewed per format by the decoder
    typedef struct packed {
        logic [4:0]  opcode;
        logic [10:0] body;
    } instr_t;

    // ALU function after operand inversion
    // PASSB forwards operand B, used by LBI
    typedef enum logic [1:0] {
        ALU_ADD   = 2'd0,
        ALU_XOR   = 2'd1,
        ALU_ANDN  = 2'd2,
        ALU_PASSB = 2'd3
    } aluOp_t;

    // Register write-back source
    typedef enum logic [1:0] {
        WB_ALU  = 2'd0,
        WB_MEM  = 2'd1,
        WB_LINK = 2'd2
    } writeSel_t;

    // Decoded control word
    typedef struct packed {
        logic      regWrite;
        writeSel_t writeSel;
        // Resolved destination register
        regIdx_t   destSel;
        logic      aluSrcImm;
        aluOp_t    aluOp;
        logic      invA;
        logic      invB;
        logic      cin;
        logic      memRead;
        logic      memWrite;
        logic      branch;
        logic      branchNonZero;
        logic      jump;
        logic      jumpReg;
        logic      link;
        logic      halt;
    } ctrl_t;

    // Loader port, word-addressed
    typedef struct packed {
        logic                               we;
        logic [$clog2(`CPU_IMEM_DEPTH)-1:0] addr;
        instr_t                             data;
    } imemLoad_t;

    // Write-back trace
    typedef struct packed {
        logic    valid;
        regIdx_t idx;
        word_t   data;
        word_t   pc;
    } wbTrace_t;

endpackage

//--- src/cpu_consts.svh
// Core widths, memory depths, link register index and opcode values
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Datapath and storage sizes
`define CPU_WIDTH       16
`define CPU_NREGS       8
`define CPU_IMEM_DEPTH  128
`define CPU_DMEM_DEPTH  64
`define CPU_LINK_REG    7

// Opcodes, instruction bits 15:11
`define OPC_HALT   5'b00000
`define OPC_NOP    5'b00001
`define OPC_J      5'b00100
`define OPC_JR     5'b00101
`define OPC_JAL    5'b00110
`define OPC_ADDI   5'b01000
`define OPC_SUBI   5'b01001
`define OPC_XORI   5'b01010
`define OPC_ANDNI  5'b01011
`define OPC_BEQZ   5'b01100
`define OPC_BNEZ   5'b01101
`define OPC_ST     5'b10000
`define OPC_LD     5'b10001
`define OPC_LBI    5'b11000
`define OPC_RTYPE  5'b11011

`endif
